/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lsu
FILELIST = sources.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/lsu_commit_arb.sv */
// commit arbiter

`timescale 1ns/10ps

module lsu_commit_arb import lsu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    ld_valid,
    input  commit_t ld_commit,
    output logic    ld_ready,
    input  logic    st_valid,
    input  commit_t st_commit,
    output logic    st_ready,
    output logic    commit_valid,
    output commit_t commit,
    input  logic    commit_ready
);

    logic room;
    logic take;

    // register empty or draining this cycle
    assign room = !commit_valid || commit_ready;
    assign take = room && (ld_valid || st_valid);

    // loads have fixed priority
    assign ld_ready = room;
    assign st_ready = room && !ld_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (room) begin
            commit_valid <= ld_valid || st_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            commit <= ld_valid ? ld_commit : st_commit;
        end
    end

endmodule

/* rtl/lsu_pending_table.sv */
// pending load table

`timescale 1ns/10ps

module lsu_pending_table import lsu_pkg::*; #(
    parameter int QUEUE_SIZE = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc_en,
    input  pend_entry_t         alloc_entry,
    output logic [TAG_BITS-1:0] alloc_tag,
    output logic                has_free,
    output logic                is_empty,
    input  logic                release_en,
    input  logic [TAG_BITS-1:0] lookup_tag,
    output pend_entry_t         lookup_entry
);

    logic [QUEUE_SIZE-1:0] busy_q;
    logic [QUEUE_SIZE-1:0] busy_n;
    logic [TAG_BITS-1:0]   tag_q;
    logic [TAG_BITS-1:0]   tag_n;
    logic                  free_q;
    logic                  free_n;

    pend_entry_t entries [QUEUE_SIZE];

    always_comb begin
        busy_n = busy_q;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (alloc_en && tag_q == TAG_BITS'(i)) begin
                busy_n[i] = 1'b1;
            end
            if (release_en && lookup_tag == TAG_BITS'(i)) begin
                busy_n[i] = 1'b0;
            end
        end
        // lowest free slot wins
        free_n = 1'b0;
        tag_n  = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!busy_n[i]) begin
                free_n = 1'b1;
                tag_n  = TAG_BITS'(i);
            end
        end
    end

    // offered tag only moves once taken, so a stalled request keeps it
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= '0;
            tag_q  <= '0;
            free_q <= 1'b1;
        end else begin
            busy_q <= busy_n;
            if (alloc_en || !free_q) begin
                tag_q  <= tag_n;
                free_q <= free_n;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (alloc_en && tag_q == TAG_BITS'(i)) begin
                entries[i] <= alloc_entry;
            end
        end
    end

    always_comb begin
        lookup_entry = entries[0];
        for (int i = 1; i < QUEUE_SIZE; i++) begin
            if (lookup_tag == TAG_BITS'(i)) begin
                lookup_entry = entries[i];
            end
        end
    end

    assign alloc_tag = tag_q;
    assign has_free  = free_q;
    assign is_empty  = ~|busy_q;

endmodule

/* rtl/lsu_pkg.sv */
// load/store unit shared types

package lsu_pkg;

    parameter int XLEN       = 32;
    parameter int WORD_BYTES = 4;
    parameter int NUM_LANES  = 4;
    parameter int UUID_BITS  = 8;
    parameter int REG_BITS   = 5;
    // caps the pending table at 16 slots
    parameter int TAG_BITS   = 4;
    parameter int OFF_BITS   = $clog2(WORD_BYTES);
    parameter int ADDR_BITS  = XLEN - OFF_BITS;

    typedef enum logic [3:0] {
        LB    = 4'h0,
        LH    = 4'h1,
        LW    = 4'h2,
        LBU   = 4'h3,
        LHU   = 4'h4,
        SB    = 4'h5,
        SH    = 4'h6,
        SW    = 4'h7,
        FENCE = 4'h8
    } lsu_op_e;

    typedef struct packed {
        logic [UUID_BITS-1:0]           uuid;
        lsu_op_e                        op;
        logic [NUM_LANES-1:0]           tmask;
        logic [NUM_LANES-1:0][XLEN-1:0] rs1;
        logic [NUM_LANES-1:0][XLEN-1:0] rs2;
        logic [XLEN-1:0]                imm;
        logic [REG_BITS-1:0]            rd;
    } dispatch_t;

    // rw high for a store
    typedef struct packed {
        logic                                 rw;
        logic [NUM_LANES-1:0]                 mask;
        logic [NUM_LANES-1:0][ADDR_BITS-1:0]  addr;
        logic [NUM_LANES-1:0][WORD_BYTES-1:0] byteen;
        logic [NUM_LANES-1:0][XLEN-1:0]       data;
        logic [TAG_BITS-1:0]                  tag;
    } mem_req_t;

    typedef struct packed {
        logic [NUM_LANES-1:0]           mask;
        logic [NUM_LANES-1:0][XLEN-1:0] data;
        logic [TAG_BITS-1:0]            tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]           uuid;
        logic [NUM_LANES-1:0]           tmask;
        logic [REG_BITS-1:0]            rd;
        logic                           wb;
        logic [NUM_LANES-1:0][XLEN-1:0] data;
    } commit_t;

    typedef struct packed {
        logic [UUID_BITS-1:0]               uuid;
        lsu_op_e                            op;
        logic [NUM_LANES-1:0]               tmask;
        logic [REG_BITS-1:0]                rd;
        logic [NUM_LANES-1:0][OFF_BITS-1:0] offset;
    } pend_entry_t;

endpackage

/* rtl/lsu_req_format.sv */
// memory request formatter

`timescale 1ns/10ps

module lsu_req_format import lsu_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                disp_valid,
    input  dispatch_t           disp,
    output logic                disp_ready,
    output logic                mem_req_valid,
    output mem_req_t            mem_req,
    input  logic                mem_req_ready,
    input  logic                has_free,
    input  logic                is_empty,
    input  logic [TAG_BITS-1:0] alloc_tag,
    output logic                alloc_en,
    output pend_entry_t         alloc_entry,
    output logic                st_valid,
    output commit_t             st_commit,
    input  logic                st_ready
);

    logic is_load;
    logic is_fence;
    logic is_store;
    logic size_byte;
    logic size_half;
    logic fence_armed;
    logic fence_go;

    logic [NUM_LANES-1:0][XLEN-1:0]       full_addr;
    logic [NUM_LANES-1:0][OFF_BITS-1:0]   req_off;
    logic [NUM_LANES-1:0][ADDR_BITS-1:0]  req_addr;
    logic [NUM_LANES-1:0][WORD_BYTES-1:0] req_byteen;
    logic [NUM_LANES-1:0][XLEN-1:0]       req_data;

    assign is_load   = disp.op inside {LB, LH, LW, LBU, LHU};
    assign is_fence  = (disp.op == FENCE);
    assign is_store  = !is_load && !is_fence;
    assign size_byte = disp.op inside {LB, LBU, SB};
    assign size_half = disp.op inside {LH, LHU, SH};

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            full_addr[i] = disp.rs1[i] + disp.imm;
            req_off[i]   = full_addr[i][OFF_BITS-1:0];
            req_addr[i]  = full_addr[i][XLEN-1:OFF_BITS];
            if (size_byte) begin
                req_byteen[i] = WORD_BYTES'(1) << req_off[i];
            end else if (size_half) begin
                req_byteen[i] = WORD_BYTES'(3) << {req_off[i][1], 1'b0};
            end else begin
                req_byteen[i] = '1;
            end
            // store data moves up to its byte lane
            req_data[i] = disp.rs2[i] << {req_off[i], 3'b000};
        end
    end

    // fence goes one cycle after it first sees the table drained
    always_ff @(posedge clk) begin
        if (reset) begin
            fence_armed <= 1'b0;
        end else if (disp_valid && disp_ready) begin
            fence_armed <= 1'b0;
        end else if (disp_valid && is_fence && is_empty) begin
            fence_armed <= 1'b1;
        end
    end

    assign fence_go = fence_armed && is_empty;

    assign mem_req_valid = disp_valid && (is_load ? has_free : (is_store && st_ready));

    always_comb begin
        if (is_fence) begin
            disp_ready = fence_go && st_ready;
        end else if (is_load) begin
            disp_ready = mem_req_ready && has_free;
        end else begin
            disp_ready = mem_req_ready && st_ready;
        end
    end

    always_comb begin
        mem_req.rw     = is_store;
        mem_req.mask   = disp.tmask;
        mem_req.addr   = req_addr;
        mem_req.byteen = req_byteen;
        mem_req.data   = req_data;
        mem_req.tag    = alloc_tag;
    end

    assign alloc_en = disp_valid && is_load && has_free && mem_req_ready;

    always_comb begin
        alloc_entry.uuid   = disp.uuid;
        alloc_entry.op     = disp.op;
        alloc_entry.tmask  = disp.tmask;
        alloc_entry.rd     = disp.rd;
        alloc_entry.offset = req_off;
    end

    // store commits alongside its request, fence once drained
    assign st_valid = disp_valid && (is_fence ? fence_go : (is_store && mem_req_ready));

    always_comb begin
        st_commit.uuid  = disp.uuid;
        st_commit.tmask = disp.tmask;
        st_commit.rd    = '0;
        st_commit.wb    = 1'b0;
        st_commit.data  = '0;
    end

endmodule

/* rtl/lsu_rsp_format.sv */
// load response formatter

`timescale 1ns/10ps

module lsu_rsp_format import lsu_pkg::*; (
    input  logic                mem_rsp_valid,
    input  mem_rsp_t            mem_rsp,
    output logic                mem_rsp_ready,
    output logic [TAG_BITS-1:0] lookup_tag,
    input  pend_entry_t         lookup_entry,
    output logic                release_en,
    output logic                ld_valid,
    output commit_t             ld_commit,
    input  logic                ld_ready
);

    logic [NUM_LANES-1:0]           lane_on;
    logic [NUM_LANES-1:0][15:0]     rsp_half;
    logic [NUM_LANES-1:0][7:0]      rsp_byte;
    logic [NUM_LANES-1:0][XLEN-1:0] rsp_data;

    assign lookup_tag = mem_rsp.tag;
    assign lane_on    = lookup_entry.tmask & mem_rsp.mask;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rsp_half[i] = lookup_entry.offset[i][1] ? mem_rsp.data[i][31:16]
                                                    : mem_rsp.data[i][15:0];
            rsp_byte[i] = lookup_entry.offset[i][0] ? rsp_half[i][15:8] : rsp_half[i][7:0];
            case (lookup_entry.op)
                LB: begin
                    rsp_data[i] = {{(XLEN-8){rsp_byte[i][7]}}, rsp_byte[i]};
                end
                LH: begin
                    rsp_data[i] = {{(XLEN-16){rsp_half[i][15]}}, rsp_half[i]};
                end
                LBU: begin
                    rsp_data[i] = {{(XLEN-8){1'b0}}, rsp_byte[i]};
                end
                LHU: begin
                    rsp_data[i] = {{(XLEN-16){1'b0}}, rsp_half[i]};
                end
                default: begin
                    rsp_data[i] = mem_rsp.data[i];
                end
            endcase
            // inactive lanes read as zero
            if (!lane_on[i]) begin
                rsp_data[i] = '0;
            end
        end
    end

    assign ld_valid      = mem_rsp_valid;
    assign mem_rsp_ready = ld_ready;
    assign release_en    = mem_rsp_valid && ld_ready;

    always_comb begin
        ld_commit.uuid  = lookup_entry.uuid;
        ld_commit.tmask = lookup_entry.tmask;
        ld_commit.rd    = lookup_entry.rd;
        ld_commit.wb    = 1'b1;
        ld_commit.data  = rsp_data;
    end

endmodule

/* rtl/lsu_unit.sv */
// load/store unit top

`timescale 1ns/10ps

module lsu_unit import lsu_pkg::*; #(
    parameter int QUEUE_SIZE = 8
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      disp_valid,
    input  dispatch_t disp,
    output logic      disp_ready,
    output logic      mem_req_valid,
    output mem_req_t  mem_req,
    input  logic      mem_req_ready,
    input  logic      mem_rsp_valid,
    input  mem_rsp_t  mem_rsp,
    output logic      mem_rsp_ready,
    output logic      commit_valid,
    output commit_t   commit,
    input  logic      commit_ready
);

    logic                has_free;
    logic                is_empty;
    logic [TAG_BITS-1:0] alloc_tag;
    logic                alloc_en;
    pend_entry_t         alloc_entry;
    logic                release_en;
    logic [TAG_BITS-1:0] lookup_tag;
    pend_entry_t         lookup_entry;
    logic                st_valid;
    commit_t             st_commit;
    logic                st_ready;
    logic                ld_valid;
    commit_t             ld_commit;
    logic                ld_ready;

    lsu_req_format i_req_format (
        .clk           (clk),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp          (disp),
        .disp_ready    (disp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .has_free      (has_free),
        .is_empty      (is_empty),
        .alloc_tag     (alloc_tag),
        .alloc_en      (alloc_en),
        .alloc_entry   (alloc_entry),
        .st_valid      (st_valid),
        .st_commit     (st_commit),
        .st_ready      (st_ready)
    );

    lsu_pending_table #(
        .QUEUE_SIZE (QUEUE_SIZE)
    ) i_pending_table (
        .clk          (clk),
        .reset        (reset),
        .alloc_en     (alloc_en),
        .alloc_entry  (alloc_entry),
        .alloc_tag    (alloc_tag),
        .has_free     (has_free),
        .is_empty     (is_empty),
        .release_en   (release_en),
        .lookup_tag   (lookup_tag),
        .lookup_entry (lookup_entry)
    );

    lsu_rsp_format i_rsp_format (
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .lookup_tag    (lookup_tag),
        .lookup_entry  (lookup_entry),
        .release_en    (release_en),
        .ld_valid      (ld_valid),
        .ld_commit     (ld_commit),
        .ld_ready      (ld_ready)
    );

    lsu_commit_arb i_commit_arb (
        .clk          (clk),
        .reset        (reset),
        .ld_valid     (ld_valid),
        .ld_commit    (ld_commit),
        .ld_ready     (ld_ready),
        .st_valid     (st_valid),
        .st_commit    (st_commit),
        .st_ready     (st_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

/* sources.f */
rtl/lsu_pkg.sv
rtl/lsu_req_format.sv
rtl/lsu_pending_table.sv
rtl/lsu_rsp_format.sv
rtl/lsu_commit_arb.sv
rtl/lsu_unit.sv
verification/lsu_assert.sv
verification/tb_lsu_mem.sv
verification/tb_lsu.sv

/* verification/lsu_assert.sv */
// lsu interface assertions

`timescale 1ns/10ps

module lsu_assert import lsu_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     mem_req_valid,
    input logic     mem_req_ready,
    input mem_req_t mem_req,
    input logic     mem_rsp_valid,
    input logic     mem_rsp_ready,
    input logic     is_empty,
    input logic     commit_valid,
    input logic     commit_ready,
    input commit_t  commit
);

    logic lanes_enabled;

    always_comb begin
        lanes_enabled = 1'b1;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (mem_req.mask[l] && mem_req.byteen[l] == '0) begin
                lanes_enabled = 1'b0;
            end
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request dropped or changed before transfer");

    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else $error("commit dropped or changed before transfer");

    req_byteen: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> lanes_enabled)
        else $error("active lane of a memory request has no byte enabled");

    rsp_pending: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid && mem_rsp_ready |-> !is_empty)
        else $error("memory response accepted with no load pending");

endmodule

bind lsu_unit lsu_assert i_lsu_assert (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_ready (mem_rsp_ready),
    .is_empty      (is_empty),
    .commit_valid  (commit_valid),
    .commit_ready  (commit_ready),
    .commit        (commit)
);

/* verification/lsu_vectors.hex */
// uuid op tmask rs1[0..3] rs2[0..3] imm rd, then expected commit data for lanes 0..3
// op: 0 LB, 1 LH, 2 LW, 3 LBU, 4 LHU, 5 SB, 6 SH, 7 SW, 8 FENCE
00 7 f 100 104 108 10c 11111111 22222222 33333333 44444444 0 0 0 0 0 0
01 2 5 100 104 108 10c 0 0 0 0 0 3 11111111 0 33333333 0
02 2 f f0 f4 f8 fc 0 0 0 0 10 4 11111111 22222222 33333333 44444444
03 5 f 201 206 20b 20c 123456f5 1234569c 1234567a 123456c3 0 0 0 0 0 0
04 3 f 201 206 20b 20c 0 0 0 0 0 5 f5 9c 7a c3
05 0 f 201 206 20b 20c 0 0 0 0 0 6 fffffff5 ffffff9c 7a ffffffc3
06 6 f 212 214 21a 21c dead8001 1234 5555fffe aaaa7f00 0 0 0 0 0 0
07 4 f 212 214 21a 21c 0 0 0 0 0 7 8001 1234 fffe 7f00
08 1 b 212 214 21a 21c 0 0 0 0 0 8 ffff8001 1234 0 7f00
09 8 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0a 2 f 300 304 308 30c 0 0 0 0 0 a 3fc03fc0 3ec13ec1 3dc23dc2 3cc33cc3
0b 2 f 300 304 308 30c 0 0 0 0 10 b 3bc43bc4 3ac53ac5 39c639c6 38c738c7
0c 2 f 320 324 328 32c 0 0 0 0 0 c 37c837c8 36c936c9 35ca35ca 34cb34cb
0d 2 f 330 334 338 33c 0 0 0 0 0 d 33cc33cc 32cd32cd 31ce31ce 30cf30cf
0e 2 f 340 344 348 34c 0 0 0 0 0 e 2fd02fd0 2ed12ed1 2dd22dd2 2cd32cd3
0f 2 f 350 354 358 35c 0 0 0 0 0 f 2bd42bd4 2ad52ad5 29d629d6 28d728d7
10 2 f 360 364 368 36c 0 0 0 0 0 10 27d827d8 26d926d9 25da25da 24db24db
11 2 f 370 374 378 37c 0 0 0 0 0 11 23dc23dc 22dd22dd 21de21de 20df20df
12 8 f 0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* verification/tb_lsu.sv */
// load/store unit testbench

`timescale 1ns/10ps

module tb_lsu import lsu_pkg::*; ();

    localparam int NUM_VEC    = 19;
    localparam int VEC_WORDS  = 17;
    localparam int MAX_CYCLES = 40 * NUM_VEC + 200;

    logic      clk;
    logic      reset;
    logic      disp_valid;
    dispatch_t disp;
    logic      disp_ready;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    mem_rsp_t  mem_rsp;
    logic      mem_rsp_ready;
    logic      commit_valid;
    commit_t   commit;
    logic      commit_ready;

    // uuid op tmask rs1 x4 rs2 x4 imm rd expected x4 for each vector
    logic [31:0] vec_mem [VEC_WORDS*NUM_VEC];
    int          seen [NUM_VEC];
    int          errors = 0;
    int          commits_seen = 0;
    int          cycles = 0;
    int          cur_vec = 0;

    lsu_unit #(
        .QUEUE_SIZE (8)
    ) i_lsu_unit (
        .clk           (clk),
        .reset         (reset),
        .disp_valid    (disp_valid),
        .disp          (disp),
        .disp_ready    (disp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .commit_ready  (commit_ready)
    );

    tb_lsu_mem i_mem (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    task automatic check_value(input string what, input int uuid,
                               input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: uuid %0d %s is %h, expected %h", $time, uuid, what, got, exp);
        end
    endtask

    // byte lanes touched by an access of the opcode's size
    function automatic logic [3:0] lane_bytes(input logic [31:0] op, input logic [1:0] off);
        case (op)
            32'(LB), 32'(LBU), 32'(SB): begin
                lane_bytes = 4'b0001 << off;
            end
            32'(LH), 32'(LHU), 32'(SH): begin
                lane_bytes = off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_bytes = 4'b1111;
            end
        endcase
    endfunction

    task automatic check_request();
        int          base;
        logic [31:0] addr;
        logic [31:0] is_store;
        base     = cur_vec * VEC_WORDS;
        is_store = (vec_mem[base+1] >= 32'(SB)) ? 32'd1 : 32'd0;
        if (vec_mem[base+1] == 32'(FENCE)) begin
            errors++;
            $display("fence uuid %0d sent a memory request", vec_mem[base]);
        end
        check_value("request rw", vec_mem[base], 32'(mem_req.rw), is_store);
        check_value("request mask", vec_mem[base], 32'(mem_req.mask), vec_mem[base+2]);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (vec_mem[base+2][l]) begin
                addr = vec_mem[base+3+l] + vec_mem[base+11];
                check_value($sformatf("lane %0d word address", l), vec_mem[base],
                            32'(mem_req.addr[l]), addr >> 2);
                check_value($sformatf("lane %0d byte enables", l), vec_mem[base],
                            32'(mem_req.byteen[l]),
                            32'(lane_bytes(vec_mem[base+1], addr[1:0])));
            end
        end
    endtask

    task automatic drive_instr(input int v);
        int base;
        base       = v * VEC_WORDS;
        disp.uuid  = vec_mem[base][UUID_BITS-1:0];
        disp.op    = lsu_op_e'(vec_mem[base+1][3:0]);
        disp.tmask = vec_mem[base+2][NUM_LANES-1:0];
        for (int l = 0; l < NUM_LANES; l++) begin
            disp.rs1[l] = vec_mem[base+3+l];
            disp.rs2[l] = vec_mem[base+7+l];
        end
        disp.imm   = vec_mem[base+11];
        disp.rd    = vec_mem[base+12][REG_BITS-1:0];
        disp_valid = 1'b1;
    endtask

    task automatic check_commit(input commit_t c);
        int          v;
        int          base;
        logic [31:0] is_load;
        v = -1;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (vec_mem[i*VEC_WORDS] == 32'(c.uuid)) begin
                v = i;
            end
        end
        if (v < 0) begin
            errors++;
            $display("commit with unknown uuid %0d", c.uuid);
        end else if (seen[v] != 0) begin
            errors++;
            $display("uuid %0d committed more than once", c.uuid);
        end else begin
            seen[v] = 1;
            commits_seen++;
            base    = v * VEC_WORDS;
            is_load = (vec_mem[base+1] < 32'(SB)) ? 32'd1 : 32'd0;
            check_value("tmask", c.uuid, 32'(c.tmask), vec_mem[base+2]);
            check_value("wb", c.uuid, 32'(c.wb), is_load);
            check_value("rd", c.uuid, 32'(c.rd), vec_mem[base+12]);
            for (int l = 0; l < NUM_LANES; l++) begin
                check_value($sformatf("lane %0d data", l), c.uuid, c.data[l],
                            vec_mem[base+13+l]);
            end
            // a fence must trail every earlier load
            if (vec_mem[base+1] == 32'(FENCE)) begin
                for (int i = 0; i < v; i++) begin
                    if (vec_mem[i*VEC_WORDS+1] < 32'(SB) && seen[i] == 0) begin
                        errors++;
                        $display("fence uuid %0d committed before load uuid %0d",
                                 c.uuid, vec_mem[i*VEC_WORDS]);
                    end
                end
            end
        end
    endtask

    task automatic finish_run();
        for (int i = 0; i < NUM_VEC; i++) begin
            if (seen[i] == 0) begin
                errors++;
                $display("instruction uuid %0d never committed", vec_mem[i*VEC_WORDS]);
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // commit port stalls about a quarter of the time
    initial begin
        commit_ready = 1'b0;
        forever begin
            @(negedge clk);
            commit_ready = !reset && ($urandom_range(3) != 0);
        end
    end

    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            check_commit(commit);
        end
    end

    always @(posedge clk) begin
        if (!reset && mem_req_valid && mem_req_ready) begin
            check_request();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout after %0d cycles with %0d of %0d instructions committed",
                     cycles, commits_seen, NUM_VEC);
            finish_run();
        end
    end

    initial begin
        void'($urandom(32'ha743));
        reset      = 1'b1;
        disp_valid = 1'b0;
        disp       = '0;
        for (int i = 0; i < NUM_VEC; i++) begin
            seen[i] = 0;
        end
        $readmemh("verification/lsu_vectors.hex", vec_mem);
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int v = 0; v < NUM_VEC; v++) begin
            cur_vec = v;
            drive_instr(v);
            do begin
                @(posedge clk);
            end while (!disp_ready);
            @(negedge clk);
        end
        disp_valid = 1'b0;
        while (commits_seen < NUM_VEC) begin
            @(posedge clk);
        end
        // room for a stray duplicate to show up
        repeat (10) @(posedge clk);
        finish_run();
    end

endmodule

/* verification/tb_lsu_mem.sv */
// behavioral data memory

`timescale 1ns/10ps

module tb_lsu_mem import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_req_valid,
    input  mem_req_t mem_req,
    output logic     mem_req_ready,
    output logic     mem_rsp_valid,
    output mem_rsp_t mem_rsp,
    input  logic     mem_rsp_ready
);

    localparam int SLOTS = 4;

    logic [XLEN-1:0] words [256];
    logic            slot_busy [SLOTS];
    int              slot_wait [SLOTS];
    mem_rsp_t        slot_rsp  [SLOTS];
    logic            req_fire;
    mem_req_t        req_q;
    logic            rsp_fire;
    int              rsp_slot;

    // handshakes seen at the rising edge, acted on at the falling edge
    always @(posedge clk) begin
        req_fire <= mem_req_valid && mem_req_ready;
        req_q    <= mem_req;
        rsp_fire <= mem_rsp_valid && mem_rsp_ready;
    end

    initial begin
        int n;
        int k;
        int s;
        int free_slots;
        for (int a = 0; a < 256; a++) begin
            words[a] = {~a[7:0], a[7:0], ~a[7:0], a[7:0]};
        end
        for (int i = 0; i < SLOTS; i++) begin
            slot_busy[i] = 1'b0;
            slot_wait[i] = 0;
        end
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        rsp_slot      = 0;
        forever begin
            @(negedge clk);
            if (rsp_fire === 1'b1) begin
                slot_busy[rsp_slot] = 1'b0;
                mem_rsp_valid = 1'b0;
            end
            for (int i = 0; i < SLOTS; i++) begin
                if (slot_busy[i] && slot_wait[i] > 0) begin
                    slot_wait[i]--;
                end
            end
            if (req_fire === 1'b1 && req_q.rw) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (req_q.mask[l] && req_q.byteen[l][b]) begin
                            words[req_q.addr[l][7:0]][b*8 +: 8] = req_q.data[l][b*8 +: 8];
                        end
                    end
                end
            end else if (req_fire === 1'b1) begin
                s = -1;
                for (int i = SLOTS - 1; i >= 0; i--) begin
                    if (!slot_busy[i]) begin
                        s = i;
                    end
                end
                slot_busy[s]     = 1'b1;
                slot_wait[s]     = $urandom_range(4, 1);
                slot_rsp[s].mask = req_q.mask;
                slot_rsp[s].tag  = req_q.tag;
                for (int l = 0; l < NUM_LANES; l++) begin
                    slot_rsp[s].data[l] = words[req_q.addr[l][7:0]];
                end
            end
            // any ready load may go next
            if (!mem_rsp_valid) begin
                n = 0;
                for (int i = 0; i < SLOTS; i++) begin
                    if (slot_busy[i] && slot_wait[i] == 0) begin
                        n++;
                    end
                end
                if (n > 0) begin
                    k = $urandom_range(n - 1);
                    for (int i = 0; i < SLOTS; i++) begin
                        if (slot_busy[i] && slot_wait[i] == 0) begin
                            if (k == 0) begin
                                rsp_slot      = i;
                                mem_rsp       = slot_rsp[i];
                                mem_rsp_valid = 1'b1;
                            end
                            k--;
                        end
                    end
                end
            end
            free_slots = 0;
            for (int i = 0; i < SLOTS; i++) begin
                if (!slot_busy[i]) begin
                    free_slots++;
                end
            end
            // requests stall once every load slot is taken
            mem_req_ready = !reset && free_slots > 0;
        end
    end

endmodule
